// ==== hdl/lora_edge_pkg.sv ====
package lora_edge_pkg;

    // ==============================
    // Data types
    // ==============================
    typedef logic [31:0] data_t;              // Bus and register word
    typedef logic [7:0]  gpio_t;              // GPIO pin vector
    typedef logic [15:0] crc_t;               // CRC-16 value

    // Register slot map, adr selects one of 16 word slots
    typedef enum logic [3:0] {
        SLOT_GPIO_OUT = 4'd0,                 // R/W GPIO output register
        SLOT_GPIO_IN  = 4'd1,                 // R synchronised GPIO input
        SLOT_CRC16    = 4'd2,                 // R/W CRC engine bridge
        SLOT_RTC      = 4'd10,                // R/W RTC seconds
        SLOT_TIMER    = 4'd12,                // R/W countdown timer
        SLOT_WDT      = 4'd13,                // R/W watchdog kick and remaining
        SLOT_SYSINFO  = 4'd15                 // R id/version, W soft reset key
    } slot_e;

    // ==============================
    // CRC-16/CCITT-FALSE
    // ==============================
    localparam crc_t CRC_POLY = 16'h1021;     // x^16 + x^12 + x^5 + 1
    localparam crc_t CRC_SEED = 16'hFFFF;     // Value after init
    localparam int unsigned CRC_INIT_BIT = 16; // Set in a CRC16 write means init

    // ==============================
    // Identity and reset values
    // ==============================
    // Bit 1 drives the radio reset pin, high keeps the radio running
    localparam gpio_t GPIO_RESET = 8'h02;

    localparam logic [7:0] CHIP_ID = 8'h01;   // LoRa edge node
    localparam logic [7:0] VERSION = 8'h10;   // Major 1, minor 0

    // Low byte of a SYSINFO write that starts a soft reset
    localparam logic [7:0] SOFT_RESET_KEY = 8'hA5;

    // Read value of every slot outside the map
    localparam data_t UNMAPPED_READ = 32'hFFFF_FFFF;

    // Cycles the core reset is held after watchdog expiry or soft reset
    localparam int unsigned RESET_HOLD = 32;

endpackage

// ==== hdl/lora_edge_regs.sv ====
`timescale 1ns/1ps

module lora_edge_regs (
    input  logic                 clk,
    input  logic                 i_core_rst_n,
    // Wishbone classic slave
    input  logic                 i_wb_cyc,
    input  logic                 i_wb_stb,
    input  logic                 i_wb_we,
    input  lora_edge_pkg::slot_e i_wb_adr,
    input  lora_edge_pkg::data_t i_wb_dat,
    output lora_edge_pkg::data_t o_wb_dat,
    output logic                 o_wb_ack,
    // GPIO pins
    input  lora_edge_pkg::gpio_t i_gpio,
    output lora_edge_pkg::gpio_t o_gpio,
    // Peripheral status in
    input  lora_edge_pkg::data_t i_timer_count,
    input  lora_edge_pkg::data_t i_rtc_seconds,
    input  lora_edge_pkg::data_t i_wdt_remaining,
    input  lora_edge_pkg::crc_t  i_crc,
    input  logic                 i_crc_busy,
    // Write strobes out, one cycle each
    output logic                 o_timer_wr,
    output logic                 o_rtc_wr,
    output logic                 o_wdt_kick,
    output logic                 o_soft_reset,
    output logic                 o_crc_init,
    output logic                 o_crc_feed,
    output logic [7:0]           o_crc_byte,
    output lora_edge_pkg::data_t o_wr_data
);
    import lora_edge_pkg::*;

    logic  bus_live;     // Core out of reset for at least one cycle
    logic  req;          // Strobe seen and not yet acked
    logic  crc_stall;    // CRC16 write must wait for the engine
    logic  fire;         // Transaction accepted this cycle
    logic  wr_fire;      // Accepted write
    data_t rd_word;      // Read mux output
    gpio_t gpio_meta;    // First sync stage
    gpio_t gpio_sync;    // Second sync stage
    gpio_t gpio_out;

    // ==============================
    // Bus handshake
    // ==============================
    // Nothing is accepted until one clean cycle after the core reset lifts,
    // so a transaction pending across a reset hold simply stalls
    always_ff @(posedge clk) begin
        if (!i_core_rst_n) begin
            bus_live <= 1'b0;
        end else begin
            bus_live <= 1'b1;
        end
    end

    assign req       = i_wb_cyc && i_wb_stb && !o_wb_ack;
    assign crc_stall = i_wb_we && (i_wb_adr == SLOT_CRC16) && i_crc_busy; // Back-pressure
    assign fire      = req && bus_live && !crc_stall;
    assign wr_fire   = fire && i_wb_we;

    always_ff @(posedge clk) begin
        if (!i_core_rst_n) begin
            o_wb_ack <= 1'b0;
        end else begin
            o_wb_ack <= fire;                  // One ack per strobe, host drops stb after it
        end
    end

    // Read data captured in the accept cycle
    always_ff @(posedge clk) begin
        if (fire && !i_wb_we) begin
            o_wb_dat <= rd_word;
        end
    end

    // ==============================
    // Write strobes
    // ==============================
    assign o_timer_wr   = wr_fire && (i_wb_adr == SLOT_TIMER);
    assign o_rtc_wr     = wr_fire && (i_wb_adr == SLOT_RTC);
    assign o_wdt_kick   = wr_fire && (i_wb_adr == SLOT_WDT);
    assign o_soft_reset = wr_fire && (i_wb_adr == SLOT_SYSINFO)
                          && (i_wb_dat[7:0] == SOFT_RESET_KEY); // Key match only

    // Bit 16 selects init, otherwise the low byte is fed
    assign o_crc_init = wr_fire && (i_wb_adr == SLOT_CRC16) && i_wb_dat[CRC_INIT_BIT];
    assign o_crc_feed = wr_fire && (i_wb_adr == SLOT_CRC16) && !i_wb_dat[CRC_INIT_BIT];
    assign o_crc_byte = i_wb_dat[7:0];
    assign o_wr_data  = i_wb_dat;              // Shared payload for all strobes

    // ==============================
    // GPIO
    // ==============================
    always_ff @(posedge clk) begin
        if (!i_core_rst_n) begin
            gpio_out <= GPIO_RESET;            // Radio reset released
        end else if (wr_fire && (i_wb_adr == SLOT_GPIO_OUT)) begin
            gpio_out <= i_wb_dat[7:0];
        end
    end

    assign o_gpio = gpio_out;

    // Two-flop synchroniser, pins are asynchronous
    always_ff @(posedge clk) begin
        if (!i_core_rst_n) begin
            gpio_meta <= '0;
            gpio_sync <= '0;
        end else begin
            gpio_meta <= i_gpio;
            gpio_sync <= gpio_meta;
        end
    end

    // ==============================
    // Read mux
    // ==============================
    always_comb begin
        case (i_wb_adr)
            SLOT_GPIO_OUT: rd_word = {24'h0, gpio_out};
            SLOT_GPIO_IN:  rd_word = {24'h0, gpio_sync};
            SLOT_CRC16:    rd_word = {15'h0, i_crc_busy, i_crc};  // Busy above the CRC
            SLOT_RTC:      rd_word = i_rtc_seconds;
            SLOT_TIMER:    rd_word = i_timer_count;
            SLOT_WDT:      rd_word = i_wdt_remaining;
            SLOT_SYSINFO:  rd_word = {16'h0, CHIP_ID, VERSION};   // Upper half unused
            default:       rd_word = UNMAPPED_READ;
        endcase
    end

    // Ack only answers a live strobe
    a_ack_in_cycle: assert property (
        @(posedge clk) disable iff (!i_core_rst_n)
        o_wb_ack |-> (i_wb_cyc && i_wb_stb)
    );

endmodule

// ==== hdl/lora_edge_timebase.sv ====
`timescale 1ns/1ps

module lora_edge_timebase #(
    parameter int unsigned CLK_PER_US = 25,       // Clock cycles per microsecond
    parameter int unsigned US_PER_SEC = 1000000   // Ticks per RTC second
) (
    input  logic                 clk,
    input  logic                 i_core_rst_n,
    input  logic                 i_timer_wr,
    input  logic                 i_rtc_wr,
    input  lora_edge_pkg::data_t i_wr_data,
    output logic                 o_tick_us,
    output lora_edge_pkg::data_t o_timer_count,
    output lora_edge_pkg::data_t o_rtc_seconds,
    output logic                 o_timer_irq
);
    import lora_edge_pkg::*;

    localparam int DIV_W = (CLK_PER_US > 1) ? $clog2(CLK_PER_US) : 1;
    localparam int SUB_W = (US_PER_SEC > 1) ? $clog2(US_PER_SEC) : 1;
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(CLK_PER_US - 1);
    localparam logic [SUB_W-1:0] SUB_LAST = SUB_W'(US_PER_SEC - 1);

    logic [DIV_W-1:0] us_div;     // Cycle count inside the microsecond
    logic [SUB_W-1:0] sub_sec;    // Ticks inside the second
    data_t            timer_q;
    data_t            rtc_q;
    logic             irq_q;

    // ==============================
    // Microsecond tick
    // ==============================
    assign o_tick_us = (us_div == DIV_LAST);  // High on the last cycle of each period

    always_ff @(posedge clk) begin
        if (!i_core_rst_n || o_tick_us) begin
            us_div <= '0;
        end else begin
            us_div <= us_div + 1'b1;
        end
    end

    // ==============================
    // Countdown timer
    // ==============================
    always_ff @(posedge clk) begin
        if (!i_core_rst_n) begin
            timer_q <= '0;
            irq_q   <= 1'b0;
        end else if (i_timer_wr) begin
            timer_q <= i_wr_data;              // Reload also clears the interrupt
            irq_q   <= 1'b0;
        end else if (o_tick_us && (timer_q != '0)) begin
            timer_q <= timer_q - 1'b1;
            if (timer_q == 32'd1) begin
                irq_q <= 1'b1;                 // Sticky until the next write
            end
        end
    end

    assign o_timer_count = timer_q;
    assign o_timer_irq   = irq_q;

    // ==============================
    // RTC seconds
    // ==============================
    always_ff @(posedge clk) begin
        if (!i_core_rst_n) begin
            rtc_q   <= '0;
            sub_sec <= '0;
        end else if (i_rtc_wr) begin
            rtc_q   <= i_wr_data;
            sub_sec <= '0;                     // New second starts at the write
        end else if (o_tick_us) begin
            if (sub_sec == SUB_LAST) begin
                sub_sec <= '0;
                rtc_q   <= rtc_q + 1'b1;
            end else begin
                sub_sec <= sub_sec + 1'b1;
            end
        end
    end

    assign o_rtc_seconds = rtc_q;

    // The watchdog and timer count one step per tick
    a_tick_single: assert property (
        @(posedge clk) disable iff (!i_core_rst_n)
        o_tick_us |=> !o_tick_us
    );

endmodule

// ==== hdl/lora_edge_reset_ctrl.sv ====
`timescale 1ns/1ps

module lora_edge_reset_ctrl (
    input  logic                 clk,
    input  logic                 rst_reg_n,
    input  logic                 i_tick_us,
    input  logic                 i_wdt_kick,
    input  logic                 i_soft_reset,
    input  lora_edge_pkg::data_t i_wr_data,
    output lora_edge_pkg::data_t o_wdt_remaining,
    output logic                 o_core_rst_n
);
    import lora_edge_pkg::*;

    localparam int HOLD_W = $clog2(RESET_HOLD + 1);
    localparam logic [HOLD_W-1:0] HOLD_LOAD = HOLD_W'(RESET_HOLD);

    data_t             wdt_q;        // Microseconds left, 0 means disabled
    logic              wdt_expire;
    logic              trigger;
    logic [HOLD_W-1:0] hold_cnt;
    logic              core_rst_q;

    // ==============================
    // Watchdog
    // ==============================
    // A kick in the same cycle as the final tick wins over expiry
    assign wdt_expire = i_tick_us && (wdt_q == 32'd1) && !i_wdt_kick;

    always_ff @(posedge clk) begin
        if (!core_rst_q) begin
            wdt_q <= '0;                       // Disabled out of any reset
        end else if (i_wdt_kick) begin
            wdt_q <= i_wr_data;
        end else if (i_tick_us && (wdt_q != '0)) begin
            wdt_q <= wdt_q - 1'b1;
        end
    end

    assign o_wdt_remaining = wdt_q;

    // ==============================
    // Reset hold
    // ==============================
    assign trigger = wdt_expire || i_soft_reset;

    always_ff @(posedge clk) begin
        if (!rst_reg_n) begin
            hold_cnt <= '0;
        end else if (trigger) begin
            hold_cnt <= HOLD_LOAD;             // Retrigger restarts the full hold
        end else if (hold_cnt != '0) begin
            hold_cnt <= hold_cnt - 1'b1;
        end
    end

    // Released one cycle after the hold count reaches zero
    always_ff @(posedge clk) begin
        if (!rst_reg_n) begin
            core_rst_q <= 1'b0;
        end else begin
            core_rst_q <= (hold_cnt == '0);
        end
    end

    assign o_core_rst_n = core_rst_q;

    a_hold_bounded: assert property (
        @(posedge clk) disable iff (!rst_reg_n)
        hold_cnt <= HOLD_LOAD
    );

endmodule

// ==== hdl/crc16_engine.sv ====
`timescale 1ns/1ps

module crc16_engine (
    input  logic                clk,
    input  logic                i_core_rst_n,
    input  logic                i_init,
    input  logic                i_feed,
    input  logic [7:0]          i_byte,
    output lora_edge_pkg::crc_t o_crc,
    output logic                o_busy
);
    import lora_edge_pkg::*;

    crc_t       crc_q;
    logic [7:0] shift_q;      // Byte being shifted in, MSB first
    logic [3:0] bits_left;    // 8 down to 0
    logic       fb;           // Feedback bit

    assign fb     = crc_q[15] ^ shift_q[7];
    assign o_busy = (bits_left != 4'd0);
    assign o_crc  = crc_q;

    // ==============================
    // Bit-serial update
    // ==============================
    always_ff @(posedge clk) begin
        if (!i_core_rst_n) begin
            crc_q     <= CRC_SEED;
            bits_left <= 4'd0;
        end else if (i_init) begin
            crc_q     <= CRC_SEED;
            bits_left <= 4'd0;                 // Init also abandons a byte in flight
        end else if (i_feed) begin
            bits_left <= 4'd8;
        end else if (o_busy) begin
            crc_q     <= {crc_q[14:0], 1'b0} ^ (fb ? CRC_POLY : 16'h0000);
            bits_left <= bits_left - 1'b1;
        end
    end

    // Byte latch
    always_ff @(posedge clk) begin
        if (i_feed) begin
            shift_q <= i_byte;
        end else if (o_busy) begin
            shift_q <= {shift_q[6:0], 1'b0};
        end
    end

    // Register bridge withholds ack on CRC16 writes while busy
    a_no_feed_busy: assert property (
        @(posedge clk) disable iff (!i_core_rst_n)
        i_feed |-> !o_busy
    );

endmodule

// ==== hdl/lora_edge_top.sv ====
`timescale 1ns/1ps

module lora_edge_top #(
    parameter int unsigned CLK_PER_US = 25,
    parameter int unsigned US_PER_SEC = 1000000
) (
    input  logic                 clk,
    input  logic                 rst_reg_n,
    input  logic                 i_wb_cyc,
    input  logic                 i_wb_stb,
    input  logic                 i_wb_we,
    input  lora_edge_pkg::slot_e i_wb_adr,
    input  lora_edge_pkg::data_t i_wb_dat,
    input  lora_edge_pkg::gpio_t i_gpio,
    output lora_edge_pkg::data_t o_wb_dat,
    output logic                 o_wb_ack,
    output lora_edge_pkg::gpio_t o_gpio,
    output logic                 o_timer_irq
);
    import lora_edge_pkg::*;

    // ==============================
    // Internal nets
    // ==============================
    logic       core_rst_n;     // From reset controller, resets the rest
    data_t      wr_data;        // Write payload shared by the strobes
    logic       timer_wr;
    logic       rtc_wr;
    logic       wdt_kick;
    logic       soft_reset;
    logic       crc_init;
    logic       crc_feed;
    logic [7:0] crc_byte;
    logic       tick_us;
    data_t      timer_count;
    data_t      rtc_seconds;
    data_t      wdt_remaining;
    crc_t       crc;
    logic       crc_busy;

    lora_edge_regs u_regs (
        .clk             (clk),
        .i_core_rst_n    (core_rst_n),
        .i_wb_cyc        (i_wb_cyc),
        .i_wb_stb        (i_wb_stb),
        .i_wb_we         (i_wb_we),
        .i_wb_adr        (i_wb_adr),
        .i_wb_dat        (i_wb_dat),
        .o_wb_dat        (o_wb_dat),
        .o_wb_ack        (o_wb_ack),
        .i_gpio          (i_gpio),
        .o_gpio          (o_gpio),
        .i_timer_count   (timer_count),
        .i_rtc_seconds   (rtc_seconds),
        .i_wdt_remaining (wdt_remaining),
        .i_crc           (crc),
        .i_crc_busy      (crc_busy),
        .o_timer_wr      (timer_wr),
        .o_rtc_wr        (rtc_wr),
        .o_wdt_kick      (wdt_kick),
        .o_soft_reset    (soft_reset),
        .o_crc_init      (crc_init),
        .o_crc_feed      (crc_feed),
        .o_crc_byte      (crc_byte),
        .o_wr_data       (wr_data)
    );

    lora_edge_timebase #(
        .CLK_PER_US (CLK_PER_US),
        .US_PER_SEC (US_PER_SEC)
    ) u_timebase (
        .clk           (clk),
        .i_core_rst_n  (core_rst_n),
        .i_timer_wr    (timer_wr),
        .i_rtc_wr      (rtc_wr),
        .i_wr_data     (wr_data),
        .o_tick_us     (tick_us),
        .o_timer_count (timer_count),
        .o_rtc_seconds (rtc_seconds),
        .o_timer_irq   (o_timer_irq)
    );

    // Only block on the external reset, holds the others in reset
    lora_edge_reset_ctrl u_reset_ctrl (
        .clk             (clk),
        .rst_reg_n       (rst_reg_n),
        .i_tick_us       (tick_us),
        .i_wdt_kick      (wdt_kick),
        .i_soft_reset    (soft_reset),
        .i_wr_data       (wr_data),
        .o_wdt_remaining (wdt_remaining),
        .o_core_rst_n    (core_rst_n)
    );

    crc16_engine u_crc16 (
        .clk          (clk),
        .i_core_rst_n (core_rst_n),
        .i_init       (crc_init),
        .i_feed       (crc_feed),
        .i_byte       (crc_byte),
        .o_crc        (crc),
        .o_busy       (crc_busy)
    );

endmodule

// ==== dv/tb_lora_edge_top.sv ====
`timescale 1ns/1ps

module tb_lora_edge_top;
    import lora_edge_pkg::*;

    localparam int CLK_PER_US  = 4;
    localparam int US_PER_SEC  = 20;
    localparam int ACK_TIMEOUT = 200;        // Covers a full reset hold

    logic  clk;
    logic  rst_reg_n;
    logic  wb_cyc;
    logic  wb_stb;
    logic  wb_we;
    slot_e wb_adr;
    data_t wb_dat;
    gpio_t gpio_in;
    data_t o_wb_dat;
    logic  o_wb_ack;
    gpio_t o_gpio;
    logic  o_timer_irq;

    logic [31:0] lfsr_state;
    gpio_t       gpio_shadow;                 // Model of GPIO_OUT
    crc_t        crc_shadow;                  // Model of the CRC register
    int          errors;
    int          tests_run;
    int          tests_failed;

    lora_edge_top #(
        .CLK_PER_US (CLK_PER_US),
        .US_PER_SEC (US_PER_SEC)
    ) dut (
        .clk         (clk),
        .rst_reg_n   (rst_reg_n),
        .i_wb_cyc    (wb_cyc),
        .i_wb_stb    (wb_stb),
        .i_wb_we     (wb_we),
        .i_wb_adr    (wb_adr),
        .i_wb_dat    (wb_dat),
        .i_gpio      (gpio_in),
        .o_wb_dat    (o_wb_dat),
        .o_wb_ack    (o_wb_ack),
        .o_gpio      (o_gpio),
        .o_timer_irq (o_timer_irq)
    );

    always #4 clk = ~clk;                     // 8 ns period

    // ==============================
    // Random source and model
    // ==============================
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];     // Taps 32,22,2,1
        return {s[30:0], fb};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state); // One step per bit
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // CRC-16/CCITT-FALSE, MSB first
    function automatic crc_t crc_model_byte(input crc_t c, input logic [7:0] b);
        int i;
        for (i = 7; i >= 0; i--) begin
            c = {c[14:0], 1'b0} ^ ((c[15] ^ b[i]) ? CRC_POLY : 16'h0000);
        end
        return c;
    endfunction

    function automatic bit is_mapped(input logic [3:0] a);
        return a inside {SLOT_GPIO_OUT, SLOT_GPIO_IN, SLOT_CRC16, SLOT_RTC,
                         SLOT_TIMER, SLOT_WDT, SLOT_SYSINFO};
    endfunction

    // ==============================
    // Bus and reporting tasks
    // ==============================
    task automatic report_mismatch(input string sig, input data_t exp, input data_t act);
        $display("[FAIL] %0t ns %s expected 0x%08h got 0x%08h", $time, sig, exp, act);
        errors++;
    endtask

    task automatic finish_test(input string name, input int err_at_start);
        tests_run++;
        if (errors == err_at_start) begin
            $display("test %-10s ok", name);
        end else begin
            tests_failed++;
            $display("test %-10s %0d error(s)", name, errors - err_at_start);
        end
    endtask

    // One classic cycle, held until ack or timeout
    task automatic bus_access(input logic we, input logic [3:0] slot, input data_t wdata,
                              output data_t rdata);
        bit ack_seen;
        int waited;
        ack_seen = 1'b0;
        waited   = 0;
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we  <= we;
        wb_adr <= slot_e'(slot);
        wb_dat <= wdata;
        while (!ack_seen && waited < ACK_TIMEOUT) begin
            @(negedge clk);                   // Ack and data settled here
            ack_seen = o_wb_ack;
            waited++;
        end
        rdata = o_wb_dat;
        if (!ack_seen) begin
            $display("timeout: no ack from slot %0d after %0d cycles", slot, ACK_TIMEOUT);
            errors++;
        end
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
        @(negedge clk);                       // Caller samples mid-cycle
    endtask

    task automatic wb_write(input logic [3:0] slot, input data_t data);
        data_t unused;
        bus_access(1'b1, slot, data, unused);
    endtask

    task automatic wb_read(input logic [3:0] slot, output data_t data);
        bus_access(1'b0, slot, '0, data);
    endtask

    task automatic set_gpio_random();
        gpio_shadow = take_bits(8);
        if (gpio_shadow == GPIO_RESET) gpio_shadow = gpio_shadow ^ 8'h80; // Must differ
        wb_write(SLOT_GPIO_OUT, {24'h0, gpio_shadow});
    endtask

    // Core reset shows up as GPIO_OUT falling back to its reset value
    task automatic wait_for_gpio_reset(input int limit);
        int waited;
        waited = 0;
        while (o_gpio !== GPIO_RESET && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        if (o_gpio !== GPIO_RESET) begin
            $display("core reset did not clear GPIO_OUT within %0d cycles", limit);
            errors++;
        end
        gpio_shadow = GPIO_RESET;
    endtask

    // ==============================
    // Test sequence
    // ==============================
    initial begin
        data_t       rd;
        data_t       prev;
        data_t       wval;
        logic [3:0]  a;
        int          e0;
        int          n;
        int          tries;
        clk = 1'b0;
        rst_reg_n = 1'b0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = SLOT_GPIO_OUT;
        wb_dat = '0;
        gpio_in = '0;
        lfsr_state = 32'd65551;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        repeat (4) @(posedge clk);
        rst_reg_n <= 1'b1;

        // Reset values
        e0 = errors;
        gpio_shadow = GPIO_RESET;
        crc_shadow  = CRC_SEED;
        wb_read(SLOT_SYSINFO, rd);
        if (rd !== {16'h0, CHIP_ID, VERSION}) begin
            report_mismatch("SYSINFO", {16'h0, CHIP_ID, VERSION}, rd);
        end
        if (o_gpio !== GPIO_RESET) report_mismatch("o_gpio", GPIO_RESET, o_gpio);
        if (o_timer_irq !== 1'b0) report_mismatch("o_timer_irq", 0, o_timer_irq);
        wb_read(SLOT_CRC16, rd);
        if (rd !== {16'h0, CRC_SEED}) report_mismatch("CRC16", {16'h0, CRC_SEED}, rd);
        n = 0;
        tries = 0;
        while (n < 4 && tries < 64) begin
            a = take_bits(4);
            tries++;
            if (!is_mapped(a)) begin
                wb_read(a, rd);
                if (rd !== UNMAPPED_READ) report_mismatch("unmapped", UNMAPPED_READ, rd);
                n++;
            end
        end
        finish_test("reset", e0);

        // GPIO out and synchronised in
        e0 = errors;
        repeat (4) begin
            set_gpio_random();
            if (o_gpio !== gpio_shadow) report_mismatch("o_gpio", gpio_shadow, o_gpio);
            wb_read(SLOT_GPIO_OUT, rd);
            if (rd !== {24'h0, gpio_shadow}) report_mismatch("GPIO_OUT", {24'h0, gpio_shadow}, rd);
        end
        @(posedge clk);
        gpio_in <= take_bits(8);
        repeat (3) @(posedge clk);            // Two sync stages plus margin
        wb_read(SLOT_GPIO_IN, rd);
        if (rd !== {24'h0, gpio_in}) report_mismatch("GPIO_IN", {24'h0, gpio_in}, rd);
        finish_test("gpio", e0);

        // CRC over 16 bytes, back to back
        e0 = errors;
        wb_write(SLOT_CRC16, 32'(1) << CRC_INIT_BIT);
        crc_shadow = CRC_SEED;
        repeat (16) begin
            wval = take_bits(8);
            wb_write(SLOT_CRC16, wval);       // Ack waits out busy
            crc_shadow = crc_model_byte(crc_shadow, wval[7:0]);
        end
        rd = 32'h0001_0000;
        tries = 0;
        while (rd[16] && tries < 20) begin
            wb_read(SLOT_CRC16, rd);
            tries++;
        end
        if (rd !== {16'h0, crc_shadow}) report_mismatch("CRC16", {16'h0, crc_shadow}, rd);
        finish_test("crc", e0);

        // Countdown timer
        e0 = errors;
        wb_write(SLOT_TIMER, 32'd5);
        tries = 0;
        while (!o_timer_irq && tries < 40 * CLK_PER_US) begin
            @(negedge clk);
            tries++;
        end
        if (!o_timer_irq) begin
            $display("timer interrupt did not rise within 40 ticks");
            errors++;
        end
        wb_read(SLOT_TIMER, rd);
        if (rd !== 32'd0) report_mismatch("TIMER", 0, rd);
        wb_write(SLOT_TIMER, take_bits(8) | 32'h100);
        if (o_timer_irq !== 1'b0) report_mismatch("o_timer_irq", 0, o_timer_irq);
        finish_test("timer", e0);

        // RTC seconds
        e0 = errors;
        wval = take_bits(16);
        wb_write(SLOT_RTC, wval);
        wb_read(SLOT_RTC, prev);
        if (prev < wval) report_mismatch("RTC", wval, prev);
        rd = prev;
        tries = 0;
        while (rd <= prev && tries < 60) begin // About two seconds of reads
            wb_read(SLOT_RTC, rd);
            tries++;
        end
        if (rd <= prev) begin
            $display("RTC did not advance past %0d", prev);
            errors++;
        end
        finish_test("rtc", e0);

        // Watchdog expiry, soft reset, then kicks in time
        e0 = errors;
        set_gpio_random();
        wval = 2 + take_bits(2);
        wb_write(SLOT_WDT, wval);
        wait_for_gpio_reset((wval + 2) * CLK_PER_US + 8);
        wb_read(SLOT_GPIO_OUT, rd);          // Stalls through the hold
        if (rd !== {24'h0, gpio_shadow}) report_mismatch("GPIO_OUT", {24'h0, gpio_shadow}, rd);
        wb_read(SLOT_WDT, rd);
        if (rd !== 32'd0) report_mismatch("WDT", 0, rd);
        set_gpio_random();
        wb_write(SLOT_WDT, 32'd1000 + take_bits(8)); // Far from expiry, only the reset clears it
        wb_write(SLOT_SYSINFO, (take_bits(24) << 8) | SOFT_RESET_KEY);
        wait_for_gpio_reset(16);
        wb_read(SLOT_GPIO_OUT, rd);
        if (rd !== {24'h0, gpio_shadow}) report_mismatch("GPIO_OUT", {24'h0, gpio_shadow}, rd);
        wb_read(SLOT_WDT, rd);
        if (rd !== 32'd0) report_mismatch("WDT", 0, rd);
        set_gpio_random();
        repeat (8) begin
            wb_write(SLOT_WDT, 32'd6);        // 24 cycles to expiry
            repeat (3 * CLK_PER_US) @(negedge clk);
        end
        if (o_gpio !== gpio_shadow) report_mismatch("o_gpio", gpio_shadow, o_gpio);
        wb_read(SLOT_GPIO_OUT, rd);
        if (rd !== {24'h0, gpio_shadow}) report_mismatch("GPIO_OUT", {24'h0, gpio_shadow}, rd);
        wb_write(SLOT_WDT, 32'd0);            // Disable again
        finish_test("watchdog", e0);

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== lora_edge_top.f ====
hdl/lora_edge_pkg.sv
hdl/lora_edge_regs.sv
hdl/lora_edge_timebase.sv
hdl/lora_edge_reset_ctrl.sv
hdl/crc16_engine.sv
hdl/lora_edge_top.sv
dv/tb_lora_edge_top.sv
